//--- omegaNet.f
common/omegaPkg.sv
verilog/rrArbiter.sv
verilog/spillStage.sv
switch/streamSwitch.sv
verilog/omegaNet.sv
verilog/omegaTop.sv
bench/tbClock.sv
bench/tbOmega.sv

//--- Bender.yml
package:
  name: omegaNet

sources:
  # Shared package first, then the RTL from the leaves upward.
  - common/omegaPkg.sv
  - verilog/rrArbiter.sv
  - verilog/spillStage.sv
  - switch/streamSwitch.sv
  - verilog/omegaNet.sv
  - verilog/omegaTop.sv
  - target: simulation
    files:
      - bench/tbClock.sv
      - bench/tbOmega.sv

//--- bench/tbOmega.sv
`timescale 1ns/1ps
// Testbench for the omega network top level.
// Payloads carry {source, sequence}, so the scoreboard needs no DUT state.
// Sequence numbers are 13 bits wide, which limits each source to 8192 packets.
// Inputs change on the falling edge, checks sample on the rising edge.
module tbOmega
  import omegaPkg::*;
;

  localparam int RandQuota   = 40;
  localparam int HotQuota    = 20;
  localparam int HotDst      = 5;
  localparam int PlannedPkts = NumPorts * NumPorts + NumPorts * (RandQuota + HotQuota);
  localparam int ClkPeriod   = 20;

  logic clk, arstN;
  payload_t [NumPorts-1:0] payload_i, payload_o;
  portIdx_t [NumPorts-1:0] dst_i, src_o;
  logic [NumPorts-1:0] valid_i, ready_o, valid_o, ready_i;
  // Inputs that completed a transfer at the last rising edge.
  logic [NumPorts-1:0] accepted;

  int errCount = 0;
  int sentTotal = 0;
  int deliveredTotal = 0;
  int seqCnt [NumPorts];
  int lastSeq [NumPorts][NumPorts];
  bit delivered [NumPorts][8192];
  portIdx_t sentDst [NumPorts][8192];
  logic [15:0] lfsrState = 16'd30023;

  // Expected single packet while the network is idle.
  logic     directMode = 1'b0;
  portIdx_t expDst, expSrc;
  payload_t expPayload;

  tbClock uClk (.clk_o(clk), .arstN_o(arstN));

  omegaTop DUT (
    .clk_i     (clk),
    .arstN_i   (arstN),
    .payload_i (payload_i),
    .dst_i     (dst_i),
    .valid_i   (valid_i),
    .ready_o   (ready_o),
    .payload_o (payload_o),
    .src_o     (src_o),
    .valid_o   (valid_o),
    .ready_i   (ready_i)
  );

  // Fibonacci LFSR with taps 16, 14, 13, 11, stepped once per bit taken.
  function automatic logic [15:0] randBits(int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int b = 0; b < n; b++) begin
      fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], fb};
      v = {v[14:0], fb};
    end
    return v;
  endfunction

  // Puts a new numbered packet on input s and records where it must go.
  task automatic makePacket(int s, portIdx_t d);
    payload_i[s] = {3'(s), 13'(seqCnt[s])};
    dst_i[s] = d;
    sentDst[s][seqCnt[s]] = d;
    seqCnt[s]++;
    sentTotal++;
    valid_i[s] = 1'b1;
  endtask

  // One packet through an idle network, followed by enough idle cycles to drain.
  task automatic sendSingle(int s, int d);
    @(negedge clk);
    expDst = portIdx_t'(d);
    expSrc = portIdx_t'(s);
    expPayload = {3'(s), 13'(seqCnt[s])};
    makePacket(s, portIdx_t'(d));
    @(negedge clk);
    valid_i[s] = 1'b0;
    repeat (5) @(negedge clk);
  endtask

  // Streams quota packets per input. A hot value of 0 or more sends all of
  // them to that output, otherwise destinations and gaps are random.
  task automatic driveTraffic(int quota, int hot, bit stallReady);
    int target [NumPorts];
    bit busy;
    for (int i = 0; i < NumPorts; i++) target[i] = seqCnt[i] + quota;
    do begin
      @(negedge clk);
      busy = 1'b0;
      for (int i = 0; i < NumPorts; i++) begin
        if (valid_i[i] && !accepted[i]) begin
          busy = 1'b1;
        end else begin
          valid_i[i] = 1'b0;
          if (seqCnt[i] < target[i]) begin
            busy = 1'b1;
            if (hot >= 0) makePacket(i, portIdx_t'(hot));
            else if (randBits(2) != 0) makePacket(i, portIdx_t'(randBits(3)));
          end
        end
      end
      for (int o = 0; o < NumPorts; o++) ready_i[o] = stallReady ? (randBits(2) != 0) : 1'b1;
    end while (busy);
    ready_i = '1;
  endtask

  always @(posedge clk) accepted <= valid_i & ready_o;

  // Scoreboard for every output transfer.
  always @(posedge clk) begin : scoreboard
    int s, q;
    if (arstN) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (valid_o[o] && ready_i[o]) begin
          s = payload_o[o][15:13];
          q = payload_o[o][12:0];
          assert (src_o[o] == portIdx_t'(s)) else begin
            errCount++;
            $display("Error t=%0t signal=src_o[%0d] expected=%0d actual=%0d",
                     $time, o, s, src_o[o]);
          end
          assert (q < seqCnt[s] && sentDst[s][q] == portIdx_t'(o)) else begin
            errCount++;
            $display("Error t=%0t signal=valid_o[%0d] expected=%0d actual=%0d",
                     $time, o, sentDst[s][q], o);
          end
          assert (!delivered[s][q]) else begin
            errCount++;
            $display("Packet %0d from input %0d was delivered twice", q, s);
          end
          assert (q > lastSeq[s][o]) else begin
            errCount++;
            $display("Packet %0d from input %0d to output %0d arrived out of order", q, s, o);
          end
          delivered[s][q] = 1'b1;
          lastSeq[s][o] = q;
          deliveredTotal++;
        end
      end
    end
  end

  // An idle input offer is taken at once, and appears three cycles later.
  for (genvar p = 0; p < NumPorts; p++) begin : genInChecks
    assert property (@(posedge clk) disable iff (!arstN) directMode && valid_i[p] |-> ready_o[p])
    else begin
      errCount++;
      $display("Input %0d was not accepted while the network was idle", p);
    end
    // A stalled output holds valid, payload and source.
    assert property (@(posedge clk) disable iff (!arstN)
                     valid_o[p] && !ready_i[p] |=> valid_o[p])
    else begin
      errCount++;
      $display("Error t=%0t signal=valid_o[%0d] expected=1 actual=0", $time, p);
    end
    assert property (@(posedge clk) disable iff (!arstN)
                     valid_o[p] && !ready_i[p] |=> $stable(payload_o[p]))
    else begin
      errCount++;
      $display("Error t=%0t signal=payload_o[%0d] expected=%h actual=%h",
               $time, p, $past(payload_o[p]), $sampled(payload_o[p]));
    end
    assert property (@(posedge clk) disable iff (!arstN)
                     valid_o[p] && !ready_i[p] |=> $stable(src_o[p]))
    else begin
      errCount++;
      $display("Error t=%0t signal=src_o[%0d] expected=%0d actual=%0d",
               $time, p, $past(src_o[p]), $sampled(src_o[p]));
    end
  end

  assert property (@(posedge clk) disable iff (!arstN)
                   directMode && |(valid_i & ready_o) |-> ##3 valid_o[expDst])
  else begin
    errCount++;
    $display("Error t=%0t signal=valid_o[%0d] expected=1 actual=0", $time, expDst);
  end
  assert property (@(posedge clk) disable iff (!arstN)
                   directMode && |(valid_i & ready_o) |-> ##3
                   (payload_o[expDst] == expPayload))
  else begin
    errCount++;
    $display("Error t=%0t signal=payload_o[%0d] expected=%h actual=%h",
             $time, expDst, expPayload, $sampled(payload_o[expDst]));
  end
  assert property (@(posedge clk) disable iff (!arstN)
                   directMode && |(valid_i & ready_o) |-> ##3
                   (src_o[expDst] == expSrc))
  else begin
    errCount++;
    $display("Error t=%0t signal=src_o[%0d] expected=%0d actual=%0d",
             $time, expDst, expSrc, $sampled(src_o[expDst]));
  end

  // Watchdog sized from the planned packet count.
  initial begin
    #(PlannedPkts * 40 * ClkPeriod);
    $display("Timeout: %0d of %0d packets delivered, %0d errors",
             deliveredTotal, sentTotal, errCount);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    valid_i = '0;
    ready_i = '1;
    payload_i = '0;
    dst_i = '0;
    for (int i = 0; i < NumPorts; i++) begin
      seqCnt[i] = 0;
      for (int o = 0; o < NumPorts; o++) lastSeq[i][o] = -1;
    end
    @(posedge arstN);
    @(negedge clk);
    assert (valid_o == '0) else begin
      errCount++;
      $display("Error t=%0t signal=valid_o expected=%h actual=%h", $time, 8'h00, valid_o);
    end
    assert (ready_o == '1) else begin
      errCount++;
      $display("Error t=%0t signal=ready_o expected=%h actual=%h", $time, 8'hff, ready_o);
    end
    directMode = 1'b1;
    for (int s = 0; s < NumPorts; s++) begin
      for (int d = 0; d < NumPorts; d++) sendSingle(s, d);
    end
    directMode = 1'b0;
    driveTraffic(RandQuota, -1, 1'b1);
    driveTraffic(HotQuota, HotDst, 1'b0);
    wait (deliveredTotal == sentTotal);
    repeat (4) @(negedge clk);
    $display("Done: %0d errors, %0d sent, %0d delivered", errCount, sentTotal, deliveredTotal);
    if (errCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- bench/tbClock.sv
`timescale 1ns/1ps
// Clock and reset source for the testbench.
// 20 ns period. Reset is held low for 8 cycles, released on a falling edge.
module tbClock (
  output logic clk_o,
  output logic arstN_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release on a falling edge keeps it away from the sampling edge.
  initial begin
    arstN_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    arstN_o = 1'b1;
  end

endmodule

//--- verilog/omegaTop.sv
`timescale 1ns/1ps
// Top level of the 8-by-8 omega network with per-port buses.
// Each flit is tagged with its input index, returned on src_o.
// Idle latency is three cycles; contention and stalls add to it.
module omegaTop
  import omegaPkg::*;
(
  input  logic                    clk_i,
  input  logic                    arstN_i,
  input  payload_t [NumPorts-1:0] payload_i,
  input  portIdx_t [NumPorts-1:0] dst_i,
  input  logic     [NumPorts-1:0] valid_i,
  output logic     [NumPorts-1:0] ready_o,
  output payload_t [NumPorts-1:0] payload_o,
  output portIdx_t [NumPorts-1:0] src_o,
  output logic     [NumPorts-1:0] valid_o,
  input  logic     [NumPorts-1:0] ready_i
);

  flit_t [NumPorts-1:0] inFlit, outFlit;

  // Pack at the inputs and unpack at the outputs.
  for (genvar i = 0; i < NumPorts; i++) begin : genPorts
    assign inFlit[i]    = '{dst: dst_i[i], payload: payload_i[i], src: portIdx_t'(i)};
    assign payload_o[i] = outFlit[i].payload;
    assign src_o[i]     = outFlit[i].src;
  end

  omegaNet uNet (
    .clk_i,
    .arstN_i,
    .inData_i   (inFlit),
    .inValid_i  (valid_i),
    .inReady_o  (ready_o),
    .outData_o  (outFlit),
    .outValid_o (valid_o),
    .outReady_i (ready_i)
  );

endmodule

//--- verilog/omegaNet.sv
`timescale 1ns/1ps
// Three-level omega network of 2-by-2 stream switches.
// A perfect shuffle precedes every level, the first one included.
// Inputs enter in reversed lane order, outputs leave in lane order.
// The topology blocks, so latency grows under contention.
module omegaNet
  import omegaPkg::*;
(
  input  logic                 clk_i,
  input  logic                 arstN_i,
  input  flit_t [NumPorts-1:0] inData_i,
  input  logic  [NumPorts-1:0] inValid_i,
  output logic  [NumPorts-1:0] inReady_o,
  output flit_t [NumPorts-1:0] outData_o,
  output logic  [NumPorts-1:0] outValid_o,
  input  logic  [NumPorts-1:0] outReady_i
);

  // Switch ports, indexed [level][switch][port].
  flit_t [NumLevels-1:0][NumSwitches-1:0][Radix-1:0] swInData;
  logic  [NumLevels-1:0][NumSwitches-1:0][Radix-1:0] swInValid, swInReady;
  flit_t [NumLevels-1:0][NumSwitches-1:0][Radix-1:0] swOutData;
  logic  [NumLevels-1:0][NumSwitches-1:0][Radix-1:0] swOutValid, swOutReady;

  // Injection. Lane l is fed by input NumPorts-1-l and is shuffled onto
  // switch l mod NumSwitches, port l div NumSwitches.
  for (genvar lane = 0; lane < NumPorts; lane++) begin : genInject
    localparam int unsigned InIdx = NumPorts - 1 - lane;
    assign swInData[0][lane % NumSwitches][lane / NumSwitches]  = inData_i[InIdx];
    assign swInValid[0][lane % NumSwitches][lane / NumSwitches] = inValid_i[InIdx];
    assign inReady_o[InIdx] = swInReady[0][lane % NumSwitches][lane / NumSwitches];
  end

  // Perfect shuffle between consecutive levels.
  // Output port k of switch j is lane 2j+k of its level.
  for (genvar lv = 0; lv < NumLevels - 1; lv++) begin : genShuffle
    for (genvar j = 0; j < NumSwitches; j++) begin : genSw
      for (genvar k = 0; k < Radix; k++) begin : genPort
        localparam int unsigned Lane = Radix * j + k;
        assign swInData[lv+1][Lane % NumSwitches][Lane / NumSwitches]  = swOutData[lv][j][k];
        assign swInValid[lv+1][Lane % NumSwitches][Lane / NumSwitches] = swOutValid[lv][j][k];
        // Ready runs the same link backwards.
        assign swOutReady[lv][j][k] = swInReady[lv+1][Lane % NumSwitches][Lane / NumSwitches];
      end
    end
  end

  // Switch array. Each level routes by its own destination bit.
  for (genvar lv = 0; lv < NumLevels; lv++) begin : genLevel
    for (genvar j = 0; j < NumSwitches; j++) begin : genSwitch
      streamSwitch #(
        .Level (lv)
      ) uSwitch (
        .clk_i,
        .arstN_i,
        .inData_i   (swInData[lv][j]),
        .inValid_i  (swInValid[lv][j]),
        .inReady_o  (swInReady[lv][j]),
        .outData_o  (swOutData[lv][j]),
        .outValid_o (swOutValid[lv][j]),
        .outReady_i (swOutReady[lv][j])
      );
    end
  end

  // Ejection. Output o is port o mod 2 of switch o div 2 in the last level.
  for (genvar o = 0; o < NumPorts; o++) begin : genEject
    assign outData_o[o]  = swOutData[NumLevels-1][o / Radix][o % Radix];
    assign outValid_o[o] = swOutValid[NumLevels-1][o / Radix][o % Radix];
    assign swOutReady[NumLevels-1][o / Radix][o % Radix] = outReady_i[o];
  end

endmodule

//--- switch/streamSwitch.sv
`timescale 1ns/1ps
// 2-by-2 stream switch for one level of the omega network.
// Each flit is steered by one destination bit, the MSB at level 0.
// Every output is registered, so a flit needs exactly one cycle to pass.
// Inputs must hold valid and data until accepted.
module streamSwitch
  import omegaPkg::*;
#(
  parameter int unsigned Level = 0
) (
  input  logic              clk_i,
  input  logic              arstN_i,
  input  flit_t [Radix-1:0] inData_i,
  input  logic  [Radix-1:0] inValid_i,
  output logic  [Radix-1:0] inReady_o,
  output flit_t [Radix-1:0] outData_o,
  output logic  [Radix-1:0] outValid_o,
  input  logic  [Radix-1:0] outReady_i
);

  // Destination bit this level routes by.
  localparam int unsigned RouteBit = NumLevels - 1 - Level;

  // Request and grant matrices are indexed [output][input].
  logic [Radix-1:0][Radix-1:0] req;
  logic [Radix-1:0][Radix-1:0] gnt;
  // Ready of each output spill stage.
  logic [Radix-1:0]            spillReady;

  for (genvar o = 0; o < Radix; o++) begin : genOut
    // Winner flit and its valid, as offered to the spill stage.
    flit_t muxData;
    logic  muxValid;

    // An input requests this output when its routing bit names it.
    for (genvar k = 0; k < Radix; k++) begin : genReq
      assign req[o][k] = inValid_i[k] && (inData_i[k].dst[RouteBit] == 1'(o));
    end

    // The arbiter is released once the spill stage takes the winner.
    rrArbiter uArb (
      .clk_i,
      .arstN_i,
      .req_i    (req[o]),
      .accept_i (muxValid && spillReady[o]),
      .gnt_o    (gnt[o])
    );

    // One-hot grant selects the flit for this output.
    always_comb begin
      muxData = '0;
      for (int k = 0; k < Radix; k++) begin
        if (gnt[o][k]) muxData = inData_i[k];
      end
    end

    assign muxValid = |(req[o] & gnt[o]);

    // The spill stage gives the output its register and holds it stable
    // while the next level stalls.
    spillStage #(
      .item_t (flit_t)
    ) uSpill (
      .clk_i,
      .arstN_i,
      .data_i  (muxData),
      .valid_i (muxValid),
      .ready_o (spillReady[o]),
      .data_o  (outData_o[o]),
      .valid_o (outValid_o[o]),
      .ready_i (outReady_i[o])
    );
  end

  // An idle input shows ready. An input that offers a flit is ready only
  // when it holds the grant of an output whose spill stage can take the
  // flit this cycle.
  always_comb begin
    inReady_o = ~inValid_i;
    for (int o = 0; o < Radix; o++) begin
      for (int k = 0; k < Radix; k++) begin
        if (gnt[o][k] && spillReady[o]) inReady_o[k] = 1'b1;
      end
    end
  end

endmodule

//--- verilog/spillStage.sv
`timescale 1ns/1ps
// Two-entry register slice for valid/ready streams.
// Both valid and ready are registered, so no combinational path crosses it.
// Throughput is one item per cycle while the downstream side is ready.
module spillStage #(
  parameter type item_t = logic
) (
  input  logic  clk_i,
  input  logic  arstN_i,
  input  item_t data_i,
  input  logic  valid_i,
  output logic  ready_o,
  output item_t data_o,
  output logic  valid_o,
  input  logic  ready_i
);

  // Entry A is presented at the output, entry B catches the skid.
  item_t aData, bData;
  logic  aFull, bFull;
  logic  accept, drain, aLoad, bLoad, aFromB;

  assign accept = valid_i && ready_o;
  assign drain  = aFull && ready_i;

  // New data goes to A if it is free or being emptied, otherwise to B.
  // B can only be loaded while it is empty, since ready_o is low when full.
  assign aLoad  = accept && (!aFull || drain);
  assign bLoad  = accept && aFull && !drain;
  assign aFromB = bFull && drain;

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      aFull <= 1'b0;
      bFull <= 1'b0;
    end else begin
      if (aLoad || aFromB) aFull <= 1'b1;
      else if (drain)      aFull <= 1'b0;
      if (bLoad)       bFull <= 1'b1;
      else if (aFromB) bFull <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aFromB)     aData <= bData;
    else if (aLoad) aData <= data_i;
    if (bLoad) bData <= data_i;
  end

  assign ready_o = !bFull;
  assign valid_o = aFull;
  assign data_o  = aData;

endmodule

//--- verilog/rrArbiter.sv
`timescale 1ns/1ps
// Round-robin arbiter for one switch output.
// Grants are combinational and follow req_i in the same cycle.
// A grant stays locked until accept_i, so a granted request must stay high
// until it is served, which stream valid rules already guarantee.
module rrArbiter
  import omegaPkg::*;
(
  input  logic             clk_i,
  input  logic             arstN_i,
  input  logic [Radix-1:0] req_i,
  input  logic             accept_i,
  output logic [Radix-1:0] gnt_o
);

  // Index of the last requester that completed a transfer.
  logic [$clog2(Radix)-1:0] lastIdx;
  // Grant held over from a cycle where the winner was not accepted.
  logic                     lockActive;
  logic [Radix-1:0]         lockGnt;
  logic [$clog2(Radix)-1:0] lockIdx;
  // Fresh round-robin choice and its index.
  logic [Radix-1:0]         rrGnt;
  logic [$clog2(Radix)-1:0] rrIdx;
  logic [$clog2(Radix)-1:0] winIdx;

  // Search starts one past the last winner and wraps around.
  // The first active request found wins.
  always_comb begin : rrPick
    int unsigned cand;
    rrGnt = '0;
    rrIdx = lastIdx;
    for (int unsigned off = 1; off <= Radix; off++) begin
      cand = (int'(lastIdx) + off) % Radix;
      if (req_i[cand] && (rrGnt == '0)) begin
        rrGnt[cand] = 1'b1;
        rrIdx = cand[$clog2(Radix)-1:0];
      end
    end
  end

  // A locked grant overrides the fresh choice until it is accepted.
  assign gnt_o  = lockActive ? lockGnt : rrGnt;
  assign winIdx = lockActive ? lockIdx : rrIdx;

  // The pointer moves only on acceptance, which keeps the order fair.
  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      lastIdx    <= $clog2(Radix)'(Radix - 1);
      lockActive <= 1'b0;
      lockGnt    <= '0;
      lockIdx    <= '0;
    end else if (gnt_o != '0) begin
      if (accept_i) begin
        lockActive <= 1'b0;
        lastIdx    <= winIdx;
      end else begin
        lockActive <= 1'b1;
        lockGnt    <= gnt_o;
        lockIdx    <= winIdx;
      end
    end
  end

endmodule

//--- common/omegaPkg.sv
// Shared constants and types for the 8-by-8 omega network.
// The network is fixed at radix 2 with three levels.
// NumPorts must stay a power of Radix for the shuffle wiring to hold.
// Flits carry the full destination so each level can pick its own bit.
package omegaPkg;

  // Number of network inputs and outputs.
  localparam int unsigned NumPorts = 8;

  // Ports per switch. The routing logic assumes one destination bit per level.
  localparam int unsigned Radix = 2;

  // Number of switch levels, log2 of NumPorts.
  localparam int unsigned NumLevels = 3;

  // Switches in each level.
  localparam int unsigned NumSwitches = NumPorts / Radix;

  // Width of the user payload in bits.
  localparam int unsigned DataWidth = 16;

  // Port number, used for both the destination and the source index.
  typedef logic [$clog2(NumPorts)-1:0] portIdx_t;

  // User payload as seen at the network boundary.
  typedef logic [DataWidth-1:0] payload_t;

  // Packet as it travels between the switch levels.
  // The destination sits in the upper bits, the source index in the lower bits.
  typedef struct packed {
    portIdx_t dst;
    payload_t payload;
    portIdx_t src;
  } flit_t;

endpackage
